/* build.f */
design/receive_pkg.sv
design/capture_if.sv
design/differentiator.sv
design/sample_discriminator.sv
design/sample_buffer.sv
design/receive_top.sv
sim/receive_checker.sv
sim/receive_top_tb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
TOP       = receive_top_tb
FILE_LIST = build.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* sim/receive_top_tb.sv */
//////////////////////////////////////////////////
// testbench for the capture path with stimulus,
// test sequence and timeout
//////////////////////////////////////////////////
`timescale 1ns/100ps

module receive_top_tb;

  localparam int num_tests = 20;
  localparam int cycles_per_test = 400;
  localparam int cycle_limit = num_tests * cycles_per_test;

  logic clk;
  logic reset;
  receive_pkg::beat_t [receive_pkg::channels-1:0] adc_data;
  logic [receive_pkg::channels-1:0] adc_valid;
  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_high;
  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_low;
  logic threshold_valid;
  logic [receive_pkg::channels-1:0] diff_select;
  logic diff_select_valid;
  logic capture_start;
  logic capture_stop;
  logic dma_ready;
  receive_pkg::beat_t dma_data;
  logic dma_is_tstamp;
  logic dma_last;
  logic dma_valid;
  int error_count;
  int word_count;
  int cycle_count = 0;
  logic [31:0] rand_state;

  receive_top u_receive_top (.*);

  receive_checker u_checker (.*);

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // random numbers
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // value in [0, span), taken from the upper state bits
  function automatic int random_below(input int span);
    rand_state = lcg_next(rand_state);
    return int'(rand_state[31:8]) % span;
  endfunction

  function automatic receive_pkg::sample_t random_sample(input int range);
    return receive_pkg::sample_t'(random_below(2 * range + 1) - range);
  endfunction

  //////////////////////////////////////////////////
  // one capture followed by its readout
  task automatic run_test(input int test);
    receive_pkg::sample_t high;
    receive_pkg::sample_t low;
    logic [receive_pkg::channels-1:0] select;
    int range;
    int beats_min;
    int beats_span;
    logic gapped;
    logic random_ready;
    int beats_left [receive_pkg::channels];
    logic done;
    logic finished;
    // straddling data on raw channels unless the test says otherwise
    high = 16'sd500;
    low = -16'sd500;
    select = '0;
    range = 1000;
    beats_min = 20;
    beats_span = 41;
    gapped = test[0];
    random_ready = (test >= 14);
    if (test < 2 || (test >= 10 && test < 14) || test >= 18) begin
      // nothing sits below the minimum, so one run from beat 0
      high = 16'sh8000;
      low = 16'sh8000;
    end else if (test < 4) begin
      high = 16'sd1000;
    end else if (test[1]) begin
      // narrow hysteresis
      high = 16'sd200;
      low = 16'sd150;
    end
    if (test >= 10 && test < 14) begin
      select = test[0] ? 4'b1110 : 4'b0101;
      range = 20000;
    end else if (test >= 14 && test < 18) begin
      select = 4'(random_below(16));
    end else if (test >= 18) begin
      // more qualifying beats than a buffer holds
      beats_min = 80;
      beats_span = 21;
      gapped = 1'b0;
    end

    @(posedge clk);
    for (int c = 0; c < receive_pkg::channels; c++) begin
      threshold_high[c] <= high;
      threshold_low[c] <= low;
    end
    threshold_valid <= 1'b1;
    diff_select <= select;
    diff_select_valid <= 1'b1;
    @(posedge clk);
    threshold_valid <= 1'b0;
    diff_select_valid <= 1'b0;
    capture_start <= 1'b1;
    @(posedge clk);
    capture_start <= 1'b0;
    @(posedge clk);

    for (int c = 0; c < receive_pkg::channels; c++) begin
      beats_left[c] = beats_min + random_below(beats_span);
    end
    done = 1'b0;
    while (!done) begin
      done = 1'b1;
      for (int c = 0; c < receive_pkg::channels; c++) begin
        if (beats_left[c] > 0 && (!gapped || random_below(4) != 0)) begin
          adc_valid[c] <= 1'b1;
          for (int i = 0; i < receive_pkg::parallel_samples; i++) begin
            adc_data[c][i] <= random_sample(range);
          end
          beats_left[c]--;
        end else begin
          adc_valid[c] <= 1'b0;
        end
        if (beats_left[c] > 0) begin
          done = 1'b0;
        end
      end
      @(posedge clk);
    end
    adc_valid <= '0;

    repeat (6) @(posedge clk);
    capture_stop <= 1'b1;
    @(posedge clk);
    capture_stop <= 1'b0;

    // drain until the final word transfers
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk);
      if (dma_valid && dma_ready && dma_last) begin
        finished = 1'b1;
      end
      dma_ready <= random_ready ? (random_below(4) != 0) : 1'b1;
    end
    dma_ready <= 1'b1;
  endtask

  //////////////////////////////////////////////////
  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, readout never completed", cycle_count);
      $display("errors: %0d, words checked: %0d", error_count, word_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    adc_data = '0;
    adc_valid = '0;
    threshold_high = '0;
    threshold_low = '0;
    threshold_valid = 1'b0;
    diff_select = '0;
    diff_select_valid = 1'b0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    dma_ready = 1'b1;
    rand_state = 32'd35;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    // a few idle cycles so dma_valid is seen low after the last readout
    repeat (4) @(posedge clk);
    $display("errors: %0d, words checked: %0d", error_count, word_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* sim/receive_checker.sv */
//////////////////////////////////////////////////
// reference model of the capture path and the
// output stream comparison
//////////////////////////////////////////////////
`timescale 1ns/100ps

module receive_checker (
  input  logic                                             clk,
  input  logic                                             reset,
  input  receive_pkg::beat_t [receive_pkg::channels-1:0]   adc_data,
  input  logic [receive_pkg::channels-1:0]                 adc_valid,
  input  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_high,
  input  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_low,
  input  logic                                             threshold_valid,
  input  logic [receive_pkg::channels-1:0]                 diff_select,
  input  logic                                             diff_select_valid,
  input  logic                                             capture_start,
  input  logic                                             capture_stop,
  input  logic                                             dma_ready,
  input  receive_pkg::beat_t                               dma_data,
  input  logic                                             dma_is_tstamp,
  input  logic                                             dma_last,
  input  logic                                             dma_valid,
  output int                                               error_count,
  output int                                               word_count
);

  // one word expected on the output stream
  typedef struct packed {
    logic [receive_pkg::beat_width-1:0] data;
    logic is_tstamp;
    logic last;
  } word_t;

  word_t expected [$];
  receive_pkg::entry_t entries [receive_pkg::channels][receive_pkg::buffer_depth];
  int entry_count [receive_pkg::channels];
  int beat_index [receive_pkg::channels];
  logic [receive_pkg::channels-1:0] run_active;
  receive_pkg::sample_t prev_sample [receive_pkg::channels];
  receive_pkg::sample_t high_reg [receive_pkg::channels];
  receive_pkg::sample_t low_reg [receive_pkg::channels];
  logic [receive_pkg::channels-1:0] select_reg;
  logic armed;
  logic readout_active;

  //////////////////////////////////////////////////
  // reference functions

  // raw beat or halved first differences with the carried sample in front
  function automatic receive_pkg::beat_t condition_beat(
    input receive_pkg::beat_t raw,
    input receive_pkg::sample_t prev,
    input logic differentiate
  );
    receive_pkg::beat_t result;
    int older;
    int diff;
    logic [receive_pkg::sample_width-1:0] wrapped;
    if (!differentiate) begin
      return raw;
    end
    older = prev;
    for (int i = 0; i < receive_pkg::parallel_samples; i++) begin
      diff = int'(raw[i]) - older;
      wrapped = diff[receive_pkg::sample_width-1:0];
      // halve with the sign bit copied down
      result[i] = {wrapped[receive_pkg::sample_width-1], wrapped[receive_pkg::sample_width-1:1]};
      older = raw[i];
    end
    return result;
  endfunction

  // returns {emit, run open after this beat}
  function automatic logic [1:0] judge_beat(
    input receive_pkg::beat_t beat,
    input receive_pkg::sample_t high,
    input receive_pkg::sample_t low,
    input logic active
  );
    logic above;
    logic below;
    above = 1'b0;
    below = 1'b1;
    for (int i = 0; i < receive_pkg::parallel_samples; i++) begin
      if (beat[i] > high) begin
        above = 1'b1;
      end
      if (beat[i] >= low) begin
        below = 1'b0;
      end
    end
    if (active) begin
      return below ? 2'b00 : 2'b11;
    end
    return above ? 2'b11 : 2'b00;
  endfunction

  // header and then optional timestamp and data per entry for each channel in turn
  task automatic queue_readout();
    word_t w;
    logic final_channel;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      final_channel = (c == receive_pkg::channels - 1);
      w.data = entry_count[c];
      w.is_tstamp = 1'b0;
      w.last = final_channel && (entry_count[c] == 0);
      expected.push_back(w);
      for (int e = 0; e < entry_count[c]; e++) begin
        if (entries[c][e].start) begin
          w.data = entries[c][e].tstamp;
          w.is_tstamp = 1'b1;
          w.last = 1'b0;
          expected.push_back(w);
        end
        w.data = entries[c][e].data;
        w.is_tstamp = 1'b0;
        w.last = final_channel && (e == entry_count[c] - 1);
        expected.push_back(w);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // model update and output comparison
  always @(posedge clk) begin
    receive_pkg::beat_t cond;
    logic [1:0] verdict;
    logic was_reading;
    word_t w;
    if (reset) begin
      armed = 1'b0;
      readout_active = 1'b0;
      run_active = '0;
      select_reg = '0;
      for (int c = 0; c < receive_pkg::channels; c++) begin
        prev_sample[c] = '0;
        high_reg[c] = '0;
        low_reg[c] = '0;
        entry_count[c] = 0;
        beat_index[c] = 0;
      end
      expected.delete();
      error_count = 0;
      word_count = 0;
    end else begin
      was_reading = readout_active;
      if (dma_valid !== readout_active) begin
        $display("Error dma_valid got %h expected %h", dma_valid, readout_active);
        error_count++;
      end
      if (dma_valid && dma_ready) begin
        word_count++;
        if (expected.size() == 0) begin
          $display("extra word %h on the output stream, none was expected", dma_data);
          error_count++;
        end else begin
          w = expected.pop_front();
          if (dma_data !== w.data) begin
            $display("Error dma_data got %h expected %h", dma_data, w.data);
            error_count++;
          end
          if (dma_is_tstamp !== w.is_tstamp) begin
            $display("Error dma_is_tstamp got %h expected %h", dma_is_tstamp, w.is_tstamp);
            error_count++;
          end
          if (dma_last !== w.last) begin
            $display("Error dma_last got %h expected %h", dma_last, w.last);
            error_count++;
          end
          // the final expected word closes the readout
          if (w.last) begin
            readout_active = 1'b0;
          end
        end
        if (dma_last && expected.size() != 0) begin
          $display("readout ended with %0d expected words never sent", expected.size());
          error_count++;
          expected.delete();
          readout_active = 1'b0;
        end
      end
      // each beat is judged as it enters the DUT
      for (int c = 0; c < receive_pkg::channels; c++) begin
        if (adc_valid[c]) begin
          cond = condition_beat(adc_data[c], prev_sample[c], select_reg[c]);
          prev_sample[c] = adc_data[c][receive_pkg::parallel_samples-1];
          if (armed) begin
            verdict = judge_beat(cond, high_reg[c], low_reg[c], run_active[c]);
            if (verdict[1] && entry_count[c] < receive_pkg::buffer_depth) begin
              entries[c][entry_count[c]] = '{
                start:  !run_active[c],
                tstamp: beat_index[c],
                data:   cond
              };
              entry_count[c]++;
            end
            run_active[c] = verdict[0];
            beat_index[c]++;
          end
        end
      end
      if (threshold_valid) begin
        for (int c = 0; c < receive_pkg::channels; c++) begin
          high_reg[c] = threshold_high[c];
          low_reg[c] = threshold_low[c];
        end
      end
      if (diff_select_valid) begin
        select_reg = diff_select;
      end
      if (capture_stop) begin
        armed = 1'b0;
        if (!was_reading) begin
          queue_readout();
          readout_active = 1'b1;
        end
      end else if (capture_start && !was_reading) begin
        armed = 1'b1;
        run_active = '0;
        for (int c = 0; c < receive_pkg::channels; c++) begin
          entry_count[c] = 0;
          beat_index[c] = 0;
        end
      end
    end
  end

endmodule

/* design/receive_top.sv */
//////////////////////////////////////////////////
// capture path top level, configuration
// registers and the module chain
//////////////////////////////////////////////////
`timescale 1ns/100ps

module receive_top (
  input  logic                                             clk,
  input  logic                                             reset,
  input  receive_pkg::beat_t [receive_pkg::channels-1:0]   adc_data,
  input  logic [receive_pkg::channels-1:0]                 adc_valid,
  input  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_high,
  input  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_low,
  input  logic                                             threshold_valid,
  input  logic [receive_pkg::channels-1:0]                 diff_select,
  input  logic                                             diff_select_valid,
  input  logic                                             capture_start,
  input  logic                                             capture_stop,
  input  logic                                             dma_ready,
  output receive_pkg::beat_t                               dma_data,
  output logic                                             dma_is_tstamp,
  output logic                                             dma_last,
  output logic                                             dma_valid
);

  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_high_reg;
  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_low_reg;
  logic [receive_pkg::channels-1:0] diff_select_reg;

  receive_pkg::beat_t [receive_pkg::channels-1:0] cond_data;
  logic [receive_pkg::channels-1:0] cond_valid;
  logic busy;
  logic start_gated;

  capture_if u_capture ();

  //////////////////////////////////////////////////
  // configuration latches
  always_ff @(posedge clk) begin
    if (reset) begin
      threshold_high_reg <= '0;
      threshold_low_reg <= '0;
      diff_select_reg <= '0;
    end else begin
      if (threshold_valid) begin
        threshold_high_reg <= threshold_high;
        threshold_low_reg <= threshold_low;
      end
      if (diff_select_valid) begin
        diff_select_reg <= diff_select;
      end
    end
  end

  // no new capture while the buffers are draining
  assign start_gated = capture_start && !busy;

  differentiator u_differentiator (
    .clk         (clk),
    .reset       (reset),
    .adc_data    (adc_data),
    .adc_valid   (adc_valid),
    .diff_select (diff_select_reg),
    .cond_data   (cond_data),
    .cond_valid  (cond_valid)
  );

  sample_discriminator u_sample_discriminator (
    .clk            (clk),
    .reset          (reset),
    .cond_data      (cond_data),
    .cond_valid     (cond_valid),
    .threshold_high (threshold_high_reg),
    .threshold_low  (threshold_low_reg),
    .capture_start  (start_gated),
    .capture_stop   (capture_stop),
    .cap            (u_capture.source)
  );

  sample_buffer u_sample_buffer (
    .clk           (clk),
    .reset         (reset),
    .capture_stop  (capture_stop),
    .dma_ready     (dma_ready),
    .cap           (u_capture.sink),
    .busy          (busy),
    .dma_data      (dma_data),
    .dma_is_tstamp (dma_is_tstamp),
    .dma_last      (dma_last),
    .dma_valid     (dma_valid)
  );

endmodule

/* design/sample_buffer.sv */
//////////////////////////////////////////////////
// per-channel capture memories and the readout
// FSM onto the output stream
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sample_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               capture_stop,
  input  logic               dma_ready,
  capture_if.sink            cap,
  output logic               busy,
  output receive_pkg::beat_t dma_data,
  output logic               dma_is_tstamp,
  output logic               dma_last,
  output logic               dma_valid
);

  // state names the word currently on the stream
  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_tstamp,
    st_data
  } state_t;

  receive_pkg::entry_t mem [receive_pkg::channels][receive_pkg::buffer_depth];
  logic [receive_pkg::count_width-1:0] entry_count [receive_pkg::channels];
  logic [receive_pkg::channels-1:0] write_en;

  state_t state;
  logic [$clog2(receive_pkg::channels)-1:0] rd_channel;
  logic [receive_pkg::count_width-1:0] rd_index;
  logic [receive_pkg::count_width-1:0] next_index;
  logic [receive_pkg::count_width-1:0] rd_count;
  receive_pkg::entry_t rd_entry;
  receive_pkg::entry_t next_entry;
  logic last_channel;
  logic fire;

  //////////////////////////////////////////////////
  // capture side
  always_comb begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      // full buffer drops further entries
      write_en[c] = cap.valid[c] && (entry_count[c] < receive_pkg::buffer_depth);
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      if (write_en[c]) begin
        mem[c][entry_count[c][receive_pkg::count_width-2:0]] <= '{
          start:  cap.start[c],
          tstamp: cap.tstamp[c],
          data:   cap.data[c]
        };
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entry_count <= '{default: '0};
    end else if (fire && dma_last) begin
      // readout done, buffers are free for the next capture
      entry_count <= '{default: '0};
    end else begin
      for (int c = 0; c < receive_pkg::channels; c++) begin
        if (write_en[c]) begin
          entry_count[c] <= entry_count[c] + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // readout side
  assign rd_count = entry_count[rd_channel];
  assign next_index = rd_index + 1'b1;
  assign rd_entry = mem[rd_channel][rd_index[receive_pkg::count_width-2:0]];
  // peek ahead to see if the next entry opens a run
  assign next_entry = mem[rd_channel][next_index[receive_pkg::count_width-2:0]];
  assign last_channel = (rd_channel == receive_pkg::channels - 1);

  assign busy = (state != st_idle);
  assign dma_valid = busy;
  assign fire = dma_valid && dma_ready;
  assign dma_is_tstamp = (state == st_tstamp);

  always_comb begin
    case (state)
      st_tstamp: dma_data = rd_entry.tstamp;
      st_data:   dma_data = rd_entry.data;
      // header carries the entry count, zero extended
      default: dma_data = {{(receive_pkg::beat_width-receive_pkg::count_width){1'b0}}, rd_count};
    endcase
  end

  always_comb begin
    dma_last = 1'b0;
    if (last_channel) begin
      if (state == st_header && rd_count == '0) begin
        dma_last = 1'b1;
      end
      if (state == st_data && next_index == rd_count) begin
        dma_last = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      rd_channel <= '0;
      rd_index <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (capture_stop) begin
            state <= st_header;
            rd_channel <= '0;
            rd_index <= '0;
          end
        end
        st_header: begin
          if (fire) begin
            if (rd_count == '0) begin
              // empty channel, move on
              if (last_channel) begin
                state <= st_idle;
              end else begin
                rd_channel <= rd_channel + 1'b1;
              end
            end else begin
              // rd_index is zero here, so rd_entry is entry 0
              state <= rd_entry.start ? st_tstamp : st_data;
            end
          end
        end
        st_tstamp: begin
          if (fire) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (fire) begin
            if (next_index == rd_count) begin
              rd_index <= '0;
              if (last_channel) begin
                state <= st_idle;
              end else begin
                rd_channel <= rd_channel + 1'b1;
                state <= st_header;
              end
            end else begin
              rd_index <= next_index;
              state <= next_entry.start ? st_tstamp : st_data;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* design/sample_discriminator.sv */
//////////////////////////////////////////////////
// hysteresis run detection, beat counting and
// timestamp tagging per channel
//////////////////////////////////////////////////
`timescale 1ns/100ps

module sample_discriminator (
  input  logic                                             clk,
  input  logic                                             reset,
  input  receive_pkg::beat_t [receive_pkg::channels-1:0]   cond_data,
  input  logic [receive_pkg::channels-1:0]                 cond_valid,
  input  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_high,
  input  receive_pkg::sample_t [receive_pkg::channels-1:0] threshold_low,
  input  logic                                             capture_start,
  input  logic                                             capture_stop,
  capture_if.source                                        cap
);

  logic armed;
  // a run is open on this channel
  logic [receive_pkg::channels-1:0] run_active;
  // beat index since capture start
  logic [receive_pkg::channels-1:0][receive_pkg::tstamp_width-1:0] beat_count;
  logic [receive_pkg::channels-1:0] any_above;
  logic [receive_pkg::channels-1:0] all_below;

  //////////////////////////////////////////////////
  // threshold compares, signed
  always_comb begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      any_above[c] = 1'b0;
      all_below[c] = 1'b1;
      for (int i = 0; i < receive_pkg::parallel_samples; i++) begin
        if (cond_data[c][i] > threshold_high[c]) begin
          any_above[c] = 1'b1;
        end
        if (!(cond_data[c][i] < threshold_low[c])) begin
          all_below[c] = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // arm state, run state and counters
  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
      run_active <= '0;
      beat_count <= '0;
      cap.valid <= '0;
    end else begin
      if (capture_stop) begin
        armed <= 1'b0;
      end else if (capture_start) begin
        armed <= 1'b1;
      end
      for (int c = 0; c < receive_pkg::channels; c++) begin
        cap.valid[c] <= 1'b0;
        if (capture_start) begin
          run_active[c] <= 1'b0;
          beat_count[c] <= '0;
        end else if (armed && cond_valid[c]) begin
          beat_count[c] <= beat_count[c] + 1'b1;
          if (run_active[c]) begin
            // closing beat is dropped
            if (all_below[c]) begin
              run_active[c] <= 1'b0;
            end else begin
              cap.valid[c] <= 1'b1;
            end
          end else if (any_above[c]) begin
            run_active[c] <= 1'b1;
            cap.valid[c] <= 1'b1;
          end
        end
      end
    end
  end

  // entry fields, only read when valid is set
  always_ff @(posedge clk) begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      if (cond_valid[c]) begin
        cap.start[c] <= !run_active[c];
        cap.tstamp[c] <= beat_count[c];
        cap.data[c] <= cond_data[c];
      end
    end
  end

endmodule

/* design/differentiator.sv */
//////////////////////////////////////////////////
// per-channel first difference with raw or
// differentiated output select
//////////////////////////////////////////////////
`timescale 1ns/100ps

module differentiator (
  input  logic                                           clk,
  input  logic                                           reset,
  input  receive_pkg::beat_t [receive_pkg::channels-1:0] adc_data,
  input  logic [receive_pkg::channels-1:0]               adc_valid,
  input  logic [receive_pkg::channels-1:0]               diff_select,
  output receive_pkg::beat_t [receive_pkg::channels-1:0] cond_data,
  output logic [receive_pkg::channels-1:0]               cond_valid
);

  // last sample of the previous valid beat, kept across captures
  receive_pkg::sample_t prev_sample [receive_pkg::channels];
  receive_pkg::beat_t   diff_beat   [receive_pkg::channels];

  //////////////////////////////////////////////////
  // halved first differences
  always_comb begin
    receive_pkg::sample_t history [receive_pkg::parallel_samples+1];
    receive_pkg::sample_t delta;
    for (int c = 0; c < receive_pkg::channels; c++) begin
      // history[0] is the carried sample, then this beat
      history[0] = prev_sample[c];
      for (int i = 0; i < receive_pkg::parallel_samples; i++) begin
        history[i+1] = adc_data[c][i];
      end
      for (int i = 0; i < receive_pkg::parallel_samples; i++) begin
        // subtraction wraps at the sample width before the shift
        delta = history[i+1] - history[i];
        diff_beat[c][i] = delta >>> 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_sample <= '{default: '0};
      cond_valid <= '0;
    end else begin
      cond_valid <= adc_valid;
      for (int c = 0; c < receive_pkg::channels; c++) begin
        // carry updates in both modes
        if (adc_valid[c]) begin
          prev_sample[c] <= adc_data[c][receive_pkg::parallel_samples-1];
        end
      end
    end
  end

  // both paths go through the same register stage
  always_ff @(posedge clk) begin
    for (int c = 0; c < receive_pkg::channels; c++) begin
      if (adc_valid[c]) begin
        cond_data[c] <= diff_select[c] ? diff_beat[c] : adc_data[c];
      end
    end
  end

endmodule

/* design/capture_if.sv */
//////////////////////////////////////////////////
// discriminated beat stream, one lane per channel
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface capture_if;

  // no ready, the buffer takes every emitted beat
  logic [receive_pkg::channels-1:0] valid;
  // first beat of a run
  logic [receive_pkg::channels-1:0] start;
  logic [receive_pkg::channels-1:0][receive_pkg::tstamp_width-1:0] tstamp;
  receive_pkg::beat_t [receive_pkg::channels-1:0] data;

  modport source (
    output valid,
    output start,
    output tstamp,
    output data
  );

  modport sink (
    input valid,
    input start,
    input tstamp,
    input data
  );

endinterface

/* design/receive_pkg.sv */
//////////////////////////////////////////////////
// capture path sizes, sample and beat types and
// the buffer entry struct
//////////////////////////////////////////////////
package receive_pkg;

  //////////////////////////////////////////////////
  // geometry of the ADC front end

  // number of ADC channels
  localparam int channels = 4;
  // samples delivered per beat on each channel
  localparam int parallel_samples = 2;
  localparam int sample_width = 16;
  // one beat is also one word on the output stream
  localparam int beat_width = parallel_samples * sample_width;

  //////////////////////////////////////////////////
  // buffer sizing

  // entries per channel buffer
  localparam int buffer_depth = 64;
  localparam int tstamp_width = 32;
  // one extra bit so a full buffer can be counted
  localparam int count_width = $clog2(buffer_depth) + 1;

  //////////////////////////////////////////////////
  // data types

  // signed ADC sample
  typedef logic signed [sample_width-1:0] sample_t;

  // one beat, sample 0 in the low bits
  typedef sample_t [parallel_samples-1:0] beat_t;

  // one buffer entry
  typedef struct packed {
    // first beat of a run, gets a timestamp word on readout
    logic start;
    logic [tstamp_width-1:0] tstamp;
    beat_t data;
  } entry_t;

endpackage
